// File: fetch_unit.f
fetch_pkg.sv
fetch_entry_if.sv
fetch_addr_gen.sv
rvc_expander.sv
word_aligner.sv
instr_queue.sv
fetch_unit.sv
fetch_unit_assertions.sv
tb_fetch_unit.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_fetch_unit
FILELIST  ?= fetch_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_unit;
  import fetch_pkg::*;

  localparam int TOTAL = 400;            // Instructions to check
  localparam int LIMIT = 20 * TOTAL + 200;

  logic clk, rst, fetch_valid, rob_ready, redirect;
  instr_t fetch_data;
  instr_t instr;
  addr_t redirect_pc;
  logic fetch_req, instr_valid, instr_compressed;
  addr_t fetch_addr, instr_pc;

  logic [31:0] mem [256];
  integer seed = 32'h1cebe7b6;
  int checks = 0;
  int cycles = 0;
  int stretch = 0;
  int wait_cnt = 0;
  int redir_done = 0;
  logic pending = 1'b0;
  logic first_req = 1'b1;
  logic ready_q = 1'b0;                  // rob_ready at the previous edge
  addr_t pend_addr;
  addr_t exp_pc = RESET_PC;
  instr_t exp_instr;
  logic exp_comp;
  half_t cur_half;
  logic [31:0] r;

  fetch_unit u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "Run stopped on first error");
  endtask

  function automatic half_t read_half(input addr_t a);
    logic [31:0] w;
    w = mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic write_half(input int h, input half_t v);
    if (h % 2 == 1) mem[h / 2][31:16] = v;
    else mem[h / 2][15:0] = v;
  endtask

  // Standard RVC expansion of the supported subset
  function automatic instr_t expand_parcel(input half_t p);
    logic [4:0] rd, rs2, rdp, rsp;
    rd  = p[11:7];
    rs2 = p[6:2];
    rdp = {2'b01, p[4:2]};
    rsp = {2'b01, p[9:7]};
    case ({p[1:0], p[15:13]})
      5'b00_000: return {2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00, 5'd2, 3'b000, rdp, 7'h13};
      5'b00_010: return {5'd0, p[5], p[12:10], p[6], 2'b00, rsp, 3'b010, rdp, 7'h03};
      5'b00_110: return {5'd0, p[5], p[12], rdp, rsp, 3'b010, p[11:10], p[6], 2'b00, 7'h23};
      5'b01_000: return {{7{p[12]}}, rs2, rd, 3'b000, rd, 7'h13};
      5'b01_010: return {{7{p[12]}}, rs2, 5'd0, 3'b000, rd, 7'h13};
      5'b01_011: return (rd == 5'd0 || rd == 5'd2) ? 32'h0 : {{15{p[12]}}, rs2, rd, 7'h37};
      5'b01_100: begin
        case (p[11:10])
          2'b00: return {6'b000000, p[12], rs2, rsp, 3'b101, rsp, 7'h13};
          2'b01: return {6'b010000, p[12], rs2, rsp, 3'b101, rsp, 7'h13};
          2'b10: return {{7{p[12]}}, rs2, rsp, 3'b111, rsp, 7'h13};
          default: begin
            if (p[12]) return 32'h0;
            case (p[6:5])
              2'b00: return {7'b0100000, rdp, rsp, 3'b000, rsp, 7'h33};
              2'b01: return {7'b0000000, rdp, rsp, 3'b100, rsp, 7'h33};
              2'b10: return {7'b0000000, rdp, rsp, 3'b110, rsp, 7'h33};
              default: return {7'b0000000, rdp, rsp, 3'b111, rsp, 7'h33};
            endcase
          end
        endcase
      end
      5'b10_000: return {6'b000000, p[12], rs2, rd, 3'b001, rd, 7'h13};
      5'b10_100: begin
        if (rs2 == 5'd0) return 32'h0;
        return p[12] ? {7'b0, rs2, rd, 3'b000, rd, 7'h33} : {7'b0, rs2, 5'd0, 3'b000, rd, 7'h33};
      end
      default: return 32'h0;
    endcase
  endfunction

  // Parcel stream, half 32-bit so many straddle a word boundary
  task automatic fill_memory();
    int h;
    logic [31:0] v, w;
    half_t c;
    h = 0;
    while (h < 512) begin
      v = $random(seed);
      if (!v[1] && h < 511) begin
        w = $random(seed);
        w[1:0] = 2'b11;
        write_half(h, w[15:0]);
        write_half(h + 1, w[31:16]);
        h = h + 2;
      end else begin
        c = v[31:16];
        c[1:0] = (v[3:2] == 2'b11) ? 2'b10 : v[3:2];
        write_half(h, c);
        h = h + 1;
      end
    end
  endtask

  task automatic drive_cycle();
    fetch_valid = 1'b0;
    redirect    = 1'b0;
    if (pending) begin
      if (wait_cnt == 0) begin
        fetch_valid = 1'b1;
        fetch_data  = mem[pend_addr[9:2]];
        pending     = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
    if (fetch_req) begin
      assert (!pending) else stop_with_error("Second fetch request while one is outstanding");
      assert (fetch_addr[1:0] == 2'b00) else stop_with_error("Fetch address not word aligned");
      if (first_req) begin
        assert (fetch_addr == RESET_PC)
          else stop_with_error($sformatf("MISMATCH at %0t: first fetch_addr %h", $time,
                                         fetch_addr));
        first_req = 1'b0;
      end
      pending   = 1'b1;
      pend_addr = fetch_addr;
      r         = $random(seed);
      wait_cnt  = int'(r[7:0]) % 3;
    end
    if (checks < 80) begin
      rob_ready = 1'b1;
    end else if (stretch == 0) begin
      r         = $random(seed);
      stretch   = 1 + int'(r[5:0]);   // Up to 64 cycles at one level
      rob_ready = r[8];
    end else begin
      stretch--;
    end
    if (redir_done == 0 && checks >= 150 && pending) begin
      redirect    = 1'b1;
      redirect_pc = 32'h0000_0100;
      redir_done  = 1;
    end else if (redir_done == 1 && checks >= 280 && pending) begin
      redirect    = 1'b1;
      redirect_pc = 32'h0000_01a2;
      redir_done  = 2;
    end
  endtask

  initial begin
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_data  = '0;
    rob_ready   = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    fill_memory();
    repeat (3) begin
      @(negedge clk);
      assert (!fetch_req && !instr_valid)
        else stop_with_error("fetch_req or instr_valid high during reset");
    end
    rst = 1'b0;
    forever begin
      @(negedge clk);
      assert (u_dut.u_assertions.fail_count == 0)
        else stop_with_error("A protocol assertion on the DUT failed");
      drive_cycle();
    end
  end

  // Reference walk through memory, restarted on redirect
  always @(posedge clk) begin
    if (!rst) begin
      if (instr_valid) begin
        assert (ready_q)
          else stop_with_error("instr_valid without rob_ready high at the edge before");
        cur_half = read_half(exp_pc);
        exp_comp = (cur_half[1:0] != 2'b11);
        exp_instr = exp_comp ? expand_parcel(cur_half) : {read_half(exp_pc + 2), cur_half};
        assert (instr_pc == exp_pc)
          else stop_with_error($sformatf("MISMATCH at %0t: instr_pc %h expected %h",
                                         $time, instr_pc, exp_pc));
        assert (instr == exp_instr && instr_compressed == exp_comp)
          else stop_with_error($sformatf("MISMATCH at %0t: pc %h instr %h/%b expected %h/%b",
                                         $time, exp_pc, instr, instr_compressed,
                                         exp_instr, exp_comp));
        exp_pc = exp_pc + (exp_comp ? 32'd2 : 32'd4);
        checks++;
      end
      if (redirect) exp_pc = redirect_pc;
    end
    ready_q = rob_ready;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) stop_with_error("Timeout: not all expected instructions arrived");
  end

  initial begin
    wait (checks >= TOTAL);
    @(negedge clk);
    if (u_dut.u_assertions.fail_count != 0) begin
      stop_with_error("A protocol assertion on the DUT failed");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: fetch_unit_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit_assertions (
  input logic                    clk,
  input logic                    rst,
  input logic                    fetch_req,
  input fetch_pkg::fetch_state_e state,
  input logic [4:0]              count,
  input logic                    instr_valid,
  input logic                    redirect
);
  import fetch_pkg::*;

  int fail_count = 0;

  req_not_in_wait: assert property (@(posedge clk) disable iff (rst)
    (state == FETCH_WAIT) |-> !fetch_req)
    else begin
      fail_count++;
      $error("fetch_req high while waiting for a response");
    end

  count_in_range: assert property (@(posedge clk) disable iff (rst)
    count <= 5'(QUEUE_DEPTH))
    else begin
      fail_count++;
      $error("queue count above depth");
    end

  quiet_after_redirect: assert property (@(posedge clk) disable iff (rst)
    redirect |=> !instr_valid)
    else begin
      fail_count++;
      $error("instr_valid high in the cycle after redirect");
    end

endmodule

bind fetch_unit fetch_unit_assertions u_assertions (
  .clk         (clk),
  .rst         (rst),
  .fetch_req   (fetch_req),
  .state       (u_addr_gen.state),
  .count       (u_queue.count),
  .instr_valid (instr_valid),
  .redirect    (redirect)
);

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_valid,
  input  fetch_pkg::instr_t fetch_data,
  input  logic              rob_ready,
  input  logic              redirect,
  input  fetch_pkg::addr_t  redirect_pc,
  output logic              fetch_req,
  output fetch_pkg::addr_t  fetch_addr,
  output logic              instr_valid,
  output fetch_pkg::instr_t instr,
  output fetch_pkg::addr_t  instr_pc,
  output logic              instr_compressed
);
  import fetch_pkg::*;

  logic  room;
  logic  word_strobe;
  addr_t word_pc;

  fetch_entry_if entry ();

  fetch_addr_gen u_addr_gen (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .room        (room),
    .fetch_valid (fetch_valid),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .word_strobe (word_strobe),
    .word_pc     (word_pc)
  );

  word_aligner u_aligner (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .word_strobe (word_strobe),
    .word_pc     (word_pc),
    .fetch_data  (fetch_data),
    .entry       (entry.aligner)
  );

  instr_queue u_queue (
    .clk              (clk),
    .rst              (rst),
    .redirect         (redirect),
    .entry            (entry.queue),
    .rob_ready        (rob_ready),
    .room             (room),
    .instr_valid      (instr_valid),
    .instr            (instr),
    .instr_pc         (instr_pc),
    .instr_compressed (instr_compressed)
  );

endmodule

`default_nettype wire

// File: instr_queue.sv
`timescale 1ns/100ps
`default_nettype none

module instr_queue (
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect,
  fetch_entry_if.queue      entry,
  input  logic              rob_ready,
  output logic              room,
  output logic              instr_valid,
  output fetch_pkg::instr_t instr,
  output fetch_pkg::addr_t  instr_pc,
  output logic              instr_compressed
);
  import fetch_pkg::*;

  instr_t     q_instr [QUEUE_DEPTH];
  addr_t      q_pc [QUEUE_DEPTH];
  logic       q_comp [QUEUE_DEPTH];
  qptr_t      head;
  qptr_t      tail;
  logic [4:0] count;
  logic [1:0] push_n;
  logic       pop;

  assign push_n = {1'b0, entry.lane_valid[0]} + {1'b0, entry.lane_valid[1]};
  assign pop    = rob_ready && (count != 5'd0);
  assign room   = (count <= 5'(QUEUE_DEPTH - QUEUE_ROOM));

  always_ff @(posedge clk) begin
    if (entry.lane_valid[0]) begin
      q_instr[tail] <= entry.lane_instr[0];
      q_pc[tail]    <= entry.lane_pc[0];
      q_comp[tail]  <= entry.lane_compressed[0];
    end
    if (entry.lane_valid[1]) begin   // Only ever set with lane 0
      q_instr[tail + qptr_t'(1)] <= entry.lane_instr[1];
      q_pc[tail + qptr_t'(1)]    <= entry.lane_pc[1];
      q_comp[tail + qptr_t'(1)]  <= entry.lane_compressed[1];
    end
    if (pop) begin
      instr            <= q_instr[head];
      instr_pc         <= q_pc[head];
      instr_compressed <= q_comp[head];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      instr_valid <= 1'b0;
    end else begin
      head        <= head + qptr_t'(pop);
      tail        <= tail + qptr_t'(push_n);
      count       <= count + 5'(push_n) - 5'(pop);
      instr_valid <= pop;
    end
  end

endmodule

`default_nettype wire

// File: word_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module word_aligner (
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect,
  input  logic              word_strobe,
  input  fetch_pkg::addr_t  word_pc,
  input  fetch_pkg::instr_t fetch_data,
  fetch_entry_if.aligner    entry
);
  import fetch_pkg::*;

  half_t  lo_half;
  half_t  hi_half;
  instr_t lo_exp;
  instr_t hi_exp;
  logic   lo_full;    // Low half starts a 32-bit instruction
  logic   hi_full;
  logic   lo_valid;
  logic   hi_start;   // Upper half begins a new instruction
  logic   hi_valid;
  instr_t lo_instr;
  addr_t  lo_pc;
  addr_t  hi_pc;
  logic   held_valid;
  half_t  held_half;  // Low half of a straddling instruction
  addr_t  held_pc;

  assign lo_half = fetch_data[15:0];
  assign hi_half = fetch_data[31:16];
  assign lo_full = (lo_half[1:0] == 2'b11);
  assign hi_full = (hi_half[1:0] == 2'b11);

  rvc_expander u_lo_exp (
    .parcel   (lo_half),
    .expanded (lo_exp)
  );

  rvc_expander u_hi_exp (
    .parcel   (hi_half),
    .expanded (hi_exp)
  );

  assign lo_valid = word_strobe && (held_valid || !word_pc[1]);
  assign lo_instr = held_valid ? {lo_half, held_half} : (lo_full ? fetch_data : lo_exp);
  assign lo_pc    = held_valid ? held_pc : {word_pc[XLEN-1:2], 2'b00};
  assign hi_pc    = {word_pc[XLEN-1:2], 2'b10};
  assign hi_start = word_strobe && (held_valid || word_pc[1] || !lo_full);
  assign hi_valid = hi_start && !hi_full;

  // Pack lanes so lane 0 is always filled first
  assign entry.lane_valid[0]      = lo_valid || hi_valid;
  assign entry.lane_instr[0]      = lo_valid ? lo_instr : hi_exp;
  assign entry.lane_pc[0]         = lo_valid ? lo_pc : hi_pc;
  assign entry.lane_compressed[0] = lo_valid ? (!held_valid && !lo_full) : 1'b1;
  assign entry.lane_valid[1]      = lo_valid && hi_valid;
  assign entry.lane_instr[1]      = hi_exp;
  assign entry.lane_pc[1]         = hi_pc;
  assign entry.lane_compressed[1] = 1'b1;

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      held_valid <= 1'b0;
    end else if (word_strobe) begin
      held_valid <= hi_start && hi_full;
    end
  end

  always_ff @(posedge clk) begin
    if (word_strobe && hi_start && hi_full) begin
      held_half <= hi_half;
      held_pc   <= hi_pc;
    end
  end

endmodule

`default_nettype wire

// File: rvc_expander.sv
`timescale 1ns/100ps
`default_nettype none

module rvc_expander (
  input  fetch_pkg::half_t  parcel,
  output fetch_pkg::instr_t expanded
);
  import fetch_pkg::*;

  logic [4:0] rd_p;    // rd' / rs2' in bits 4:2
  logic [4:0] rs1_p;   // rs1' / rd' in bits 9:7
  logic [4:0] rd;
  logic [4:0] rs2;

  assign rd_p  = {2'b01, parcel[4:2]};
  assign rs1_p = {2'b01, parcel[9:7]};
  assign rd    = parcel[11:7];
  assign rs2   = parcel[6:2];

  always_comb begin
    expanded = '0;   // Unsupported encodings stay zero
    case (parcel[1:0])
      2'b00: begin
        case (parcel[15:13])
          3'b000: expanded = {2'b00, parcel[10:7], parcel[12:11], parcel[5], parcel[6],
                              2'b00, REG_SP, 3'b000, rd_p, OPC_OP_IMM};  // C.ADDI4SPN
          3'b010: expanded = {5'b00000, parcel[5], parcel[12:10], parcel[6], 2'b00,
                              rs1_p, 3'b010, rd_p, OPC_LOAD};            // C.LW
          3'b110: expanded = {5'b00000, parcel[5], parcel[12], rd_p, rs1_p, 3'b010,
                              parcel[11:10], parcel[6], 2'b00, OPC_STORE};  // C.SW
          default: expanded = '0;
        endcase
      end
      2'b01: begin
        case (parcel[15:13])
          3'b000: expanded = {{7{parcel[12]}}, rs2, rd, 3'b000, rd, OPC_OP_IMM};  // C.ADDI
          3'b010: expanded = {{7{parcel[12]}}, rs2, 5'd0, 3'b000, rd, OPC_OP_IMM};  // C.LI
          3'b011: begin
            if (rd != 5'd0 && rd != REG_SP) begin
              expanded = {{15{parcel[12]}}, rs2, rd, OPC_LUI};  // C.LUI
            end
          end
          3'b100: begin
            case (parcel[11:10])
              2'b00: expanded = {6'b000000, parcel[12], rs2, rs1_p, 3'b101, rs1_p,
                                 OPC_OP_IMM};                         // C.SRLI
              2'b01: expanded = {6'b010000, parcel[12], rs2, rs1_p, 3'b101, rs1_p,
                                 OPC_OP_IMM};                         // C.SRAI
              2'b10: expanded = {{7{parcel[12]}}, rs2, rs1_p, 3'b111, rs1_p,
                                 OPC_OP_IMM};                         // C.ANDI
              default: begin
                if (!parcel[12]) begin
                  case (parcel[6:5])
                    2'b00: expanded = {7'b0100000, rd_p, rs1_p, 3'b000, rs1_p, OPC_OP};
                    2'b01: expanded = {7'b0000000, rd_p, rs1_p, 3'b100, rs1_p, OPC_OP};
                    2'b10: expanded = {7'b0000000, rd_p, rs1_p, 3'b110, rs1_p, OPC_OP};
                    default: expanded = {7'b0000000, rd_p, rs1_p, 3'b111, rs1_p, OPC_OP};
                  endcase
                end
              end
            endcase
          end
          default: expanded = '0;
        endcase
      end
      2'b10: begin
        case (parcel[15:13])
          3'b000: expanded = {6'b000000, parcel[12], rs2, rd, 3'b001, rd, OPC_OP_IMM};  // C.SLLI
          3'b100: begin
            if (rs2 != 5'd0) begin
              if (parcel[12]) begin
                expanded = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};    // C.ADD
              end else begin
                expanded = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};  // C.MV
              end
            end
          end
          default: expanded = '0;
        endcase
      end
      default: expanded = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: fetch_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_addr_gen (
  input  logic             clk,
  input  logic             rst,
  input  logic             redirect,
  input  fetch_pkg::addr_t redirect_pc,
  input  logic             room,
  input  logic             fetch_valid,
  output logic             fetch_req,
  output fetch_pkg::addr_t fetch_addr,
  output logic             word_strobe,
  output fetch_pkg::addr_t word_pc
);
  import fetch_pkg::*;

  fetch_state_e state;
  addr_t        pc;       // First parcel wanted from the next word
  addr_t        next_pc;
  logic         stale;    // Outstanding request is on the old path

  assign next_pc     = redirect ? redirect_pc : pc;
  assign word_strobe = fetch_valid && (state == FETCH_WAIT) && !stale && !redirect;
  assign word_pc     = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= FETCH_IDLE;
      pc        <= RESET_PC;
      stale     <= 1'b0;
      fetch_req <= 1'b0;
    end else begin
      fetch_req <= 1'b0;
      pc        <= next_pc;
      case (state)
        FETCH_IDLE: begin
          if (fetch_req) begin
            state <= FETCH_WAIT;   // Request went out last edge
            stale <= redirect;
          end else if (room) begin
            fetch_req  <= 1'b1;
            fetch_addr <= {next_pc[XLEN-1:2], 2'b00};
          end
        end
        FETCH_WAIT: begin
          if (fetch_valid) begin
            state <= FETCH_IDLE;
            stale <= 1'b0;
            if (word_strobe) begin
              pc <= {pc[XLEN-1:2], 2'b00} + addr_t'(4);
            end
          end else if (redirect) begin
            stale <= 1'b1;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: fetch_entry_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fetch_entry_if;
  import fetch_pkg::*;

  logic [1:0] lane_valid;       // Lane 0 is older
  instr_t     lane_instr [2];
  addr_t      lane_pc [2];
  logic [1:0] lane_compressed;

  modport aligner (
    output lane_valid,
    output lane_instr,
    output lane_pc,
    output lane_compressed
  );

  modport queue (
    input lane_valid,
    input lane_instr,
    input lane_pc,
    input lane_compressed
  );

endinterface

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;   // Byte address
  typedef logic [XLEN-1:0] instr_t;  // Full instruction
  typedef logic [15:0]     half_t;   // Compressed parcel

  localparam int QUEUE_DEPTH = 16;
  typedef logic [3:0] qptr_t;

  // One outstanding word gives two entries at most
  localparam int QUEUE_ROOM = 4;

  localparam addr_t RESET_PC = '0;

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [4:0] REG_SP = 5'd2;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_e;

endpackage

`default_nettype wire
